// ==== dv/fifo_neighbor_link_checker.sv ====
`default_nettype none

module fifo_neighbor_link_checker (
    input wire                    clk,
    input wire                    reset,
    input wire link_pkg::stage_t  global_stage,
    input wire                    a_is_error_in,
    input wire                    peer_is_error,
    input wire                    is_error,
    input wire link_pkg::growth_t growth,
    input wire                    trigger,
    input wire                    output_fifo_valid,
    input wire                    output_fifo_ready
);

    import link_pkg::*;

    int unsigned fail_count = 0;
    logic loading;

    assign loading = (global_stage == STAGE_MEASUREMENT_LOADING);

    // a held word leaves only through a transfer or a loading clear
    valid_held: assert property (@(posedge clk) disable iff (reset)
        output_fifo_valid && !output_fifo_ready && !loading |=> output_fifo_valid)
        else begin
            $error("output_fifo_valid dropped without a transfer");
            fail_count++;
        end

    growth_bound: assert property (@(posedge clk) disable iff (reset) growth <= WEIGHT)
        else begin
            $error("growth above the link weight");
            fail_count++;
        end

    error_follows: assert property (@(posedge clk) disable iff (reset)
        !loading |=> is_error == $past(a_is_error_in | peer_is_error))
        else begin
            $error("is_error does not match the inputs of the previous cycle");
            fail_count++;
        end

    valid_after_trigger: assert property (@(posedge clk) disable iff (reset)
        trigger |=> output_fifo_valid)
        else begin
            $error("output_fifo_valid did not rise after a trigger");
            fail_count++;
        end

endmodule

bind fifo_neighbor_link fifo_neighbor_link_checker i_checker (
    .growth  (i_growth.growth),
    .trigger (i_tx.trigger),
    .*
);

`default_nettype wire

// ==== dv/fifo_neighbor_link_tb.sv ====
`default_nettype none

module fifo_neighbor_link_tb;

    import link_pkg::*;

    typedef logic [HEADER_LSB-1:BIT_PARENT_VECTOR] state_t; // word positions of the state

    localparam header_t HEADER_ID = 1;
    localparam address_t ADDRESS_B = 0;

    logic clk;
    logic reset;
    stage_t global_stage;
    logic a_increase;
    logic a_is_error_in;
    state_t a_state;
    logic input_fifo_valid;
    link_word_t input_fifo_data;
    logic output_fifo_ready;
    wire input_fifo_ready;
    wire output_fifo_valid;
    wire link_word_t output_fifo_data;
    wire state_t peer_state;
    wire fully_grown;
    wire is_error;
    int seed = 32'h116c8c12;
    int errors = 0;
    int checks = 0;
    int tests = 0;
    int test_errors = 0;
    int growth_model = 0;

    fifo_neighbor_link i_dut (
        .clk                                   (clk),
        .reset                                 (reset),
        .global_stage                          (global_stage),
        .a_increase                            (a_increase),
        .a_is_error_in                         (a_is_error_in),
        .a_root_in                             (a_state[ROOT_LSB +: ADDRESS_WIDTH]),
        .a_parent_vector_in                    (a_state[BIT_PARENT_VECTOR]),
        .a_parent_odd_in                       (a_state[BIT_PARENT_ODD]),
        .a_child_cluster_parity_in             (a_state[BIT_CLUSTER_PARITY]),
        .a_child_touching_boundary_in          (a_state[BIT_TOUCHING_BOUNDARY]),
        .a_child_peeling_complete_in           (a_state[BIT_PEELING_COMPLETE]),
        .a_child_peeling_m_in                  (a_state[BIT_PEELING_M]),
        .a_parent_peeling_parity_completed_in  (a_state[BIT_PARITY_COMPLETED]),
        .a_root_out                            (peer_state[ROOT_LSB +: ADDRESS_WIDTH]),
        .a_parent_vector_out                   (peer_state[BIT_PARENT_VECTOR]),
        .a_parent_odd_out                      (peer_state[BIT_PARENT_ODD]),
        .a_child_cluster_parity_out            (peer_state[BIT_CLUSTER_PARITY]),
        .a_child_touching_boundary_out         (peer_state[BIT_TOUCHING_BOUNDARY]),
        .a_child_peeling_complete_out          (peer_state[BIT_PEELING_COMPLETE]),
        .a_child_peeling_m_out                 (peer_state[BIT_PEELING_M]),
        .a_parent_peeling_parity_completed_out (peer_state[BIT_PARITY_COMPLETED]),
        .fully_grown                           (fully_grown),
        .is_error                              (is_error),
        .input_fifo_valid                      (input_fifo_valid),
        .input_fifo_ready                      (input_fifo_ready),
        .input_fifo_data                       (input_fifo_data),
        .output_fifo_valid                     (output_fifo_valid),
        .output_fifo_ready                     (output_fifo_ready),
        .output_fifo_data                      (output_fifo_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic link_word_t make_word(header_t hdr, logic inc, logic err, state_t s);
        link_word_t w;
        w = '0;
        w[BIT_INCREASE] = inc;
        w[BIT_ERROR] = err;
        w[HEADER_LSB-1:BIT_PARENT_VECTOR] = s;
        w[HEADER_LSB +: HEADER_WIDTH] = hdr;
        return w;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        assert (got === expected) else begin
            $display("MISMATCH at %0t: %s is %0h, expected %0h", $time, what, got, expected);
            errors++;
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        $display("test %-20s %s", name, (test_errors == 0) ? "ok" : "FAILED");
        tests++;
        test_errors = 0;
    endtask

    task automatic send_word(input header_t hdr, input logic inc, input logic err, input state_t s);
        input_fifo_valid <= 1'b1;
        input_fifo_data <= make_word(hdr, inc, err, s);
    endtask

    task automatic go_idle();
        a_increase <= 1'b0;
        a_is_error_in <= 1'b0;
        input_fifo_valid <= 1'b0;
        global_stage <= '0;
    endtask

    task automatic load_cycle();
        @(posedge clk);
        go_idle();
        global_stage <= STAGE_MEASUREMENT_LOADING;
        @(posedge clk);
        global_stage <= '0;
        growth_model = 0;
    endtask

    task automatic check_defaults();
        state_t d;
        d = '0;
        d[ROOT_LSB +: ADDRESS_WIDTH] = ADDRESS_B;
        check_value("output_fifo_valid", output_fifo_valid, 0);
        check_value("fully_grown", fully_grown, 0);
        check_value("is_error", is_error, 0);
        check_value("peer state", peer_state, d);
    endtask

    // one cycle of increments from either side, checked after the edge that counts them
    task automatic count_pulse(input logic a_inc, input logic peer_inc);
        @(posedge clk);
        a_increase <= a_inc;
        if (peer_inc) begin
            send_word(HEADER_ID, 1'b1, 1'b0, state_t'($random(seed)));
        end
        @(posedge clk);
        go_idle();
        growth_model = growth_model + a_inc + peer_inc;
        if (growth_model > WEIGHT) begin
            growth_model = WEIGHT;
        end
        @(negedge clk);
        check_value("fully_grown", fully_grown, growth_model >= WEIGHT);
    endtask

    task automatic wait_valid(input int limit);
        int n;
        n = 0;
        while (!output_fifo_valid && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!output_fifo_valid) begin
            $display("timeout: output_fifo_valid did not rise within %0d cycles", limit);
            errors++;
            test_errors++;
        end
    endtask

    initial begin
        int hold;
        logic a_err;
        logic w_err;
        logic match;
        state_t sent;

        reset = 1'b1;
        global_stage = '0;
        a_increase = 1'b0;
        a_is_error_in = 1'b0;
        a_state = '0;
        input_fifo_valid = 1'b0;
        input_fifo_data = '0;
        output_fifo_ready = 1'b0; // held word must be cleared by loading, not by a transfer
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        @(negedge clk);
        check_defaults();
        count_pulse(1'b1, 1'b1);
        load_cycle();
        output_fifo_ready <= 1'b1;
        @(negedge clk);
        check_defaults();
        finish_test("reset_and_loading");

        count_pulse(1'b1, 1'b0);
        count_pulse(1'b1, 1'b1); // both sides in one cycle
        for (int i = 0; i < 6; i++) begin
            count_pulse($random(seed), $random(seed));
        end
        repeat (3) begin
            @(negedge clk);
            check_value("fully_grown held", fully_grown, 1);
        end
        load_cycle();
        @(negedge clk);
        check_value("fully_grown after loading", fully_grown, 0);
        finish_test("growth_saturation");

        for (int i = 0; i < 4; i++) begin
            sent = state_t'($random(seed));
            @(posedge clk);
            send_word(HEADER_ID, 1'b0, 1'b0, sent);
            @(posedge clk);
            send_word(HEADER_ID ^ header_t'(1 + i % 3), 1'b1, 1'b1, ~sent); // foreign word
            @(negedge clk);
            check_value("peer state", peer_state, sent);
            check_value("input_fifo_ready", input_fifo_ready, 1);
            @(posedge clk);
            go_idle();
            @(negedge clk);
            check_value("peer state after foreign word", peer_state, sent);
            check_value("is_error after foreign word", is_error, 0);
            check_value("fully_grown after foreign word", fully_grown, 0);
        end
        finish_test("receive_and_filter");

        load_cycle();
        for (int f = BIT_PARENT_VECTOR; f < HEADER_LSB; f++) begin
            @(posedge clk);
            output_fifo_ready <= 1'b0;
            a_state[f] <= ~a_state[f];
            @(negedge clk);
            wait_valid(4);
            check_value("output_fifo_data", output_fifo_data,
                        make_word(HEADER_ID, 1'b0, 1'b0, a_state));
            hold = 1 + ($random(seed) & 3);
            repeat (hold) begin
                @(negedge clk);
                check_value("output_fifo_valid under back-pressure", output_fifo_valid, 1);
            end
            @(posedge clk);
            output_fifo_ready <= 1'b1;
            @(posedge clk); // transfer edge
            @(negedge clk);
            check_value("output_fifo_valid after transfer", output_fifo_valid, 0);
        end
        finish_test("transmit_backpressure");

        for (int i = 0; i < 8; i++) begin
            a_err = $random(seed);
            w_err = $random(seed);
            match = $random(seed);
            @(posedge clk);
            a_is_error_in <= a_err;
            send_word(match ? HEADER_ID : ~HEADER_ID, 1'b0, w_err, state_t'($random(seed)));
            @(posedge clk);
            go_idle();
            @(negedge clk);
            check_value("is_error", is_error, a_err | (w_err & match));
        end
        @(posedge clk);
        a_is_error_in <= 1'b1;
        @(posedge clk);
        global_stage <= STAGE_MEASUREMENT_LOADING;
        @(negedge clk);
        check_value("is_error before loading", is_error, 1);
        @(posedge clk);
        go_idle();
        @(negedge clk);
        check_value("is_error after loading", is_error, 0);
        finish_test("error_flag");

        errors = errors + i_dut.i_checker.fail_count;
        $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
                 tests, checks, errors, i_dut.i_checker.fail_count);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== fifo_neighbor_link.f ====
hdl/link_pkg.sv
hdl/link_growth.sv
hdl/link_tx_packer.sv
hdl/link_rx_unpacker.sv
hdl/fifo_neighbor_link.sv
dv/fifo_neighbor_link_checker.sv
dv/fifo_neighbor_link_tb.sv

// ==== hdl/fifo_neighbor_link.sv ====
`default_nettype none

module fifo_neighbor_link #(
    parameter link_pkg::header_t  HEADER_ID = 1,
    parameter link_pkg::address_t ADDRESS_A = 0,
    parameter link_pkg::address_t ADDRESS_B = 0
) (
    input  wire                       clk,
    input  wire                       reset,
    input  wire link_pkg::stage_t     global_stage,

    input  wire                       a_increase,
    input  wire                       a_is_error_in,

    // local side-a state
    input  wire link_pkg::address_t   a_root_in,
    input  wire                       a_parent_vector_in,
    input  wire                       a_parent_odd_in,
    input  wire                       a_child_cluster_parity_in,
    input  wire                       a_child_touching_boundary_in,
    input  wire                       a_child_peeling_complete_in,
    input  wire                       a_child_peeling_m_in,
    input  wire                       a_parent_peeling_parity_completed_in,

    // peer state as seen by side a
    output link_pkg::address_t        a_root_out,
    output logic                      a_parent_vector_out,
    output logic                      a_parent_odd_out,
    output logic                      a_child_cluster_parity_out,
    output logic                      a_child_touching_boundary_out,
    output logic                      a_child_peeling_complete_out,
    output logic                      a_child_peeling_m_out,
    output logic                      a_parent_peeling_parity_completed_out,

    output logic                      fully_grown,
    output logic                      is_error,

    input  wire                       input_fifo_valid,
    output logic                      input_fifo_ready,
    input  wire link_pkg::link_word_t input_fifo_data,

    output logic                      output_fifo_valid,
    input  wire                       output_fifo_ready,
    output link_pkg::link_word_t      output_fifo_data
);

    logic peer_increase;
    logic peer_is_error;

    link_growth i_growth (
        .clk           (clk),
        .reset         (reset),
        .global_stage  (global_stage),
        .a_increase    (a_increase),
        .peer_increase (peer_increase),
        .a_is_error_in (a_is_error_in),
        .peer_is_error (peer_is_error),
        .fully_grown   (fully_grown),
        .is_error      (is_error)
    );

    link_tx_packer #(
        .HEADER_ID (HEADER_ID),
        .ADDRESS_A (ADDRESS_A)
    ) i_tx (
        .clk                                  (clk),
        .reset                                (reset),
        .global_stage                         (global_stage),
        .a_increase                           (a_increase),
        .a_is_error_in                        (a_is_error_in),
        .a_root_in                            (a_root_in),
        .a_parent_vector_in                   (a_parent_vector_in),
        .a_parent_odd_in                      (a_parent_odd_in),
        .a_child_cluster_parity_in            (a_child_cluster_parity_in),
        .a_child_touching_boundary_in         (a_child_touching_boundary_in),
        .a_child_peeling_complete_in          (a_child_peeling_complete_in),
        .a_child_peeling_m_in                 (a_child_peeling_m_in),
        .a_parent_peeling_parity_completed_in (a_parent_peeling_parity_completed_in),
        .output_fifo_ready                    (output_fifo_ready),
        .output_fifo_valid                    (output_fifo_valid),
        .output_fifo_data                     (output_fifo_data)
    );

    link_rx_unpacker #(
        .HEADER_ID (HEADER_ID),
        .ADDRESS_B (ADDRESS_B)
    ) i_rx (
        .clk                                   (clk),
        .reset                                 (reset),
        .global_stage                          (global_stage),
        .input_fifo_valid                      (input_fifo_valid),
        .input_fifo_data                       (input_fifo_data),
        .input_fifo_ready                      (input_fifo_ready),
        .peer_increase                         (peer_increase),
        .peer_is_error                         (peer_is_error),
        .a_root_out                            (a_root_out),
        .a_parent_vector_out                   (a_parent_vector_out),
        .a_parent_odd_out                      (a_parent_odd_out),
        .a_child_cluster_parity_out            (a_child_cluster_parity_out),
        .a_child_touching_boundary_out         (a_child_touching_boundary_out),
        .a_child_peeling_complete_out          (a_child_peeling_complete_out),
        .a_child_peeling_m_out                 (a_child_peeling_m_out),
        .a_parent_peeling_parity_completed_out (a_parent_peeling_parity_completed_out)
    );

endmodule

`default_nettype wire

// ==== hdl/link_growth.sv ====
`default_nettype none

module link_growth (
    input  wire                  clk,
    input  wire                  reset,
    input  wire link_pkg::stage_t global_stage,
    input  wire                  a_increase,
    input  wire                  peer_increase,
    input  wire                  a_is_error_in,
    input  wire                  peer_is_error,
    output logic                 fully_grown,
    output logic                 is_error
);

    import link_pkg::*;

    growth_t growth;
    logic [$bits(growth_t):0] growth_sum; // one bit extra so both increments fit
    logic loading;

    assign loading = (global_stage == STAGE_MEASUREMENT_LOADING);

    always_comb begin
        growth_sum = {1'b0, growth} + a_increase + peer_increase;
    end

    always_ff @(posedge clk) begin
        if (reset || loading) begin
            growth <= '0;
        end else if (growth_sum > WEIGHT) begin
            growth <= growth_t'(WEIGHT); // saturate at the edge weight
        end else begin
            growth <= growth_sum[$bits(growth_t)-1:0];
        end
    end

    // error follows both sides with one cycle of delay
    always_ff @(posedge clk) begin
        if (reset || loading) begin
            is_error <= 1'b0;
        end else begin
            is_error <= a_is_error_in | peer_is_error;
        end
    end

    assign fully_grown = (growth >= WEIGHT);

endmodule

`default_nettype wire

// ==== hdl/link_pkg.sv ====
`default_nettype none

package link_pkg;

    // widths
    localparam int ADDRESS_WIDTH = 6;
    localparam int HEADER_WIDTH = 2;
    localparam int WEIGHT = 2;
    localparam int STAGE_WIDTH = 3;
    localparam int LINK_WORD_WIDTH = ADDRESS_WIDTH + 9 + HEADER_WIDTH;

    // field positions inside one fifo word
    localparam int BIT_INCREASE = 0;
    localparam int BIT_ERROR = 1;
    localparam int BIT_PARENT_VECTOR = 2;
    localparam int ROOT_LSB = 3;
    localparam int BIT_PARENT_ODD = ROOT_LSB + ADDRESS_WIDTH;
    localparam int BIT_CLUSTER_PARITY = BIT_PARENT_ODD + 1;
    localparam int BIT_TOUCHING_BOUNDARY = BIT_PARENT_ODD + 2;
    localparam int BIT_PEELING_COMPLETE = BIT_PARENT_ODD + 3;
    localparam int BIT_PEELING_M = BIT_PARENT_ODD + 4;
    localparam int BIT_PARITY_COMPLETED = BIT_PARENT_ODD + 5;
    localparam int HEADER_LSB = BIT_PARITY_COMPLETED + 1; // header sits at the top

    typedef logic [ADDRESS_WIDTH-1:0] address_t;
    typedef logic [HEADER_WIDTH-1:0] header_t;
    typedef logic [$clog2(WEIGHT+1)-1:0] growth_t;
    typedef logic [STAGE_WIDTH-1:0] stage_t;
    typedef logic [LINK_WORD_WIDTH-1:0] link_word_t;

    // decoder stage codes
    localparam stage_t STAGE_MEASUREMENT_LOADING = 3'd1;

endpackage

`default_nettype wire

// ==== hdl/link_rx_unpacker.sv ====
`default_nettype none

module link_rx_unpacker #(
    parameter link_pkg::header_t  HEADER_ID = 1,
    parameter link_pkg::address_t ADDRESS_B = 0
) (
    input  wire                      clk,
    input  wire                      reset,
    input  wire link_pkg::stage_t    global_stage,
    input  wire                      input_fifo_valid,
    input  wire link_pkg::link_word_t input_fifo_data,
    output logic                     input_fifo_ready,
    output logic                     peer_increase,
    output logic                     peer_is_error,
    output link_pkg::address_t       a_root_out,
    output logic                     a_parent_vector_out,
    output logic                     a_parent_odd_out,
    output logic                     a_child_cluster_parity_out,
    output logic                     a_child_touching_boundary_out,
    output logic                     a_child_peeling_complete_out,
    output logic                     a_child_peeling_m_out,
    output logic                     a_parent_peeling_parity_completed_out
);

    import link_pkg::*;

    logic [HEADER_LSB-1:BIT_PARENT_VECTOR] peer_state;
    logic header_match;
    logic accept;

    assign input_fifo_ready = 1'b1; // every word is taken, foreign ones dropped
    assign header_match = (input_fifo_data[HEADER_LSB +: HEADER_WIDTH] == HEADER_ID);
    assign accept = input_fifo_valid && input_fifo_ready && header_match;

    assign peer_increase = accept && input_fifo_data[BIT_INCREASE];
    assign peer_is_error = accept && input_fifo_data[BIT_ERROR];

    // a matched word takes priority over the loading clear
    always_ff @(posedge clk) begin
        if (reset) begin
            peer_state <= '0;
            peer_state[ROOT_LSB +: ADDRESS_WIDTH] <= ADDRESS_B;
        end else if (accept) begin
            peer_state <= input_fifo_data[HEADER_LSB-1:BIT_PARENT_VECTOR];
        end else if (global_stage == STAGE_MEASUREMENT_LOADING) begin
            peer_state <= '0;
            peer_state[ROOT_LSB +: ADDRESS_WIDTH] <= ADDRESS_B;
        end
    end

    assign a_root_out = peer_state[ROOT_LSB +: ADDRESS_WIDTH];
    assign a_parent_vector_out = peer_state[BIT_PARENT_VECTOR];
    assign a_parent_odd_out = peer_state[BIT_PARENT_ODD];
    assign a_child_cluster_parity_out = peer_state[BIT_CLUSTER_PARITY];
    assign a_child_touching_boundary_out = peer_state[BIT_TOUCHING_BOUNDARY];
    assign a_child_peeling_complete_out = peer_state[BIT_PEELING_COMPLETE];
    assign a_child_peeling_m_out = peer_state[BIT_PEELING_M];
    assign a_parent_peeling_parity_completed_out = peer_state[BIT_PARITY_COMPLETED];

endmodule

`default_nettype wire

// ==== hdl/link_tx_packer.sv ====
`default_nettype none

module link_tx_packer #(
    parameter link_pkg::header_t  HEADER_ID = 1,
    parameter link_pkg::address_t ADDRESS_A = 0
) (
    input  wire                     clk,
    input  wire                     reset,
    input  wire link_pkg::stage_t   global_stage,
    input  wire                     a_increase,
    input  wire                     a_is_error_in,
    input  wire link_pkg::address_t a_root_in,
    input  wire                     a_parent_vector_in,
    input  wire                     a_parent_odd_in,
    input  wire                     a_child_cluster_parity_in,
    input  wire                     a_child_touching_boundary_in,
    input  wire                     a_child_peeling_complete_in,
    input  wire                     a_child_peeling_m_in,
    input  wire                     a_parent_peeling_parity_completed_in,
    input  wire                     output_fifo_ready,
    output logic                    output_fifo_valid,
    output link_pkg::link_word_t    output_fifo_data
);

    import link_pkg::*;

    // state bits keep their word positions so slices line up with the fifo word
    logic [HEADER_LSB-1:BIT_PARENT_VECTOR] state_now;
    logic [HEADER_LSB-1:BIT_PARENT_VECTOR] state_prev;
    logic increase_sticky;
    logic error_sticky;
    logic loading;
    logic state_changed;
    logic trigger;

    assign loading = (global_stage == STAGE_MEASUREMENT_LOADING);

    always_comb begin
        state_now = '0;
        state_now[BIT_PARENT_VECTOR] = a_parent_vector_in;
        state_now[ROOT_LSB +: ADDRESS_WIDTH] = a_root_in;
        state_now[BIT_PARENT_ODD] = a_parent_odd_in;
        state_now[BIT_CLUSTER_PARITY] = a_child_cluster_parity_in;
        state_now[BIT_TOUCHING_BOUNDARY] = a_child_touching_boundary_in;
        state_now[BIT_PEELING_COMPLETE] = a_child_peeling_complete_in;
        state_now[BIT_PEELING_M] = a_child_peeling_m_in;
        state_now[BIT_PARITY_COMPLETED] = a_parent_peeling_parity_completed_in;
    end

    // previous side-a state, back to its defaults when loading
    always_ff @(posedge clk) begin
        if (reset || loading) begin
            state_prev <= '0;
            state_prev[ROOT_LSB +: ADDRESS_WIDTH] <= ADDRESS_A;
        end else begin
            state_prev <= state_now;
        end
    end

    assign state_changed = (state_now != state_prev);
    assign trigger = !loading && (a_increase || a_is_error_in || state_changed);

    always_ff @(posedge clk) begin
        if (reset || loading) begin
            increase_sticky <= 1'b0;
            error_sticky <= 1'b0;
        end else begin
            increase_sticky <= increase_sticky | a_increase;
            error_sticky <= error_sticky | a_is_error_in;
        end
    end

    // a new trigger wins over the clear after a transfer
    always_ff @(posedge clk) begin
        if (reset || loading) begin
            output_fifo_valid <= 1'b0;
        end else if (trigger) begin
            output_fifo_valid <= 1'b1;
        end else if (output_fifo_valid && output_fifo_ready) begin
            output_fifo_valid <= 1'b0;
        end
    end

    always_comb begin
        output_fifo_data = '0;
        output_fifo_data[BIT_INCREASE] = increase_sticky;
        output_fifo_data[BIT_ERROR] = error_sticky;
        output_fifo_data[HEADER_LSB-1:BIT_PARENT_VECTOR] = state_now; // live fields
        output_fifo_data[HEADER_LSB +: HEADER_WIDTH] = HEADER_ID;
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module fifo_neighbor_link_tb \
    -f fifo_neighbor_link.f --Mdir obj_dir -o sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/sim +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
echo "$output" | grep -qx "Verification passed" || exit 1
exit 0
